/* files.f */
verilog/axi_pkg.sv
verilog/cache_axi_master.sv
verilog/axi_rr_arbiter.sv
verilog/axi_sram_slave.sv
verilog/mem_subsys_top.sv
tb/mem_subsys_assertions.sv
tb/mem_subsys_tb.sv

/* tb/mem_subsys_assertions.sv */
module mem_subsys_assertions #(
    parameter int N_PORTS = 2
) (
    input logic             clk,
    input logic             rst,
    input logic             arvalid_i,
    input axi_pkg::axi_ar_t ar_i,
    input logic             arready_i,
    input logic             awvalid_i,
    input axi_pkg::axi_ar_t aw_i,
    input logic             awready_i,
    input logic             wvalid_i,
    input axi_pkg::axi_w_t  w_i,
    input logic             wready_i,
    input logic             rvalid_i,
    input axi_pkg::axi_r_t  r_i,
    input logic             rready_i,
    input logic             bvalid_i,
    input axi_pkg::axi_b_t  b_i,
    input logic             bready_i
);
    import axi_pkg::*;

    int assert_errors = 0;

    // Valid and payload hold until the transfer
    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
        else begin
            assert_errors++;
            $error("AR valid dropped or payload changed before arready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst)
        awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
        else begin
            assert_errors++;
            $error("AW valid dropped or payload changed before awready");
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst)
        wvalid_i && !wready_i |=> wvalid_i && $stable(w_i))
        else begin
            assert_errors++;
            $error("W valid dropped or payload changed before wready");
        end

    r_hold: assert property (@(posedge clk) disable iff (!rst)
        rvalid_i && !rready_i |=> rvalid_i && $stable(r_i))
        else begin
            assert_errors++;
            $error("R valid dropped or payload changed before rready");
        end

    b_hold: assert property (@(posedge clk) disable iff (!rst)
        bvalid_i && !bready_i |=> bvalid_i && $stable(b_i))
        else begin
            assert_errors++;
            $error("B valid dropped or payload changed before bready");
        end

    // One address channel at a time towards the slave
    one_addr: assert property (@(posedge clk) disable iff (!rst)
        !(arvalid_i && awvalid_i))
        else begin
            assert_errors++;
            $error("arvalid and awvalid high together");
        end

    r_id_range: assert property (@(posedge clk) disable iff (!rst)
        rvalid_i |-> (int'(r_i.id) < N_PORTS))
        else begin
            assert_errors++;
            $error("R beat returned with an ID outside the port range");
        end

    b_id_range: assert property (@(posedge clk) disable iff (!rst)
        bvalid_i |-> (int'(b_i.id) < N_PORTS))
        else begin
            assert_errors++;
            $error("B response returned with an ID outside the port range");
        end

endmodule

bind axi_rr_arbiter mem_subsys_assertions #(
    .N_PORTS (N_PORTS)
) u_assertions (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (s_arvalid_o),
    .ar_i      (s_ar_o),
    .arready_i (s_arready_i),
    .awvalid_i (s_awvalid_o),
    .aw_i      (s_aw_o),
    .awready_i (s_awready_i),
    .wvalid_i  (s_wvalid_o),
    .w_i       (s_w_o),
    .wready_i  (s_wready_i),
    .rvalid_i  (s_rvalid_i),
    .r_i       (s_r_i),
    .rready_i  (s_rready_o),
    .bvalid_i  (s_bvalid_i),
    .b_i       (s_b_i),
    .bready_i  (s_bready_o)
);

/* tb/mem_subsys_tb.sv */
module mem_subsys_tb;
    import axi_pkg::*;

    localparam int N_PORTS    = 2;
    localparam int MEM_WORDS  = 256;
    localparam int RAND_OPS   = 24;
    localparam int PORT_WORDS = MEM_WORDS / N_PORTS;
    // Worst case counts every random read as a burst
    localparam int TOTAL_BEATS = 2 + 6 + 8 + RAND_OPS * 4 * N_PORTS;
    localparam int MAX_CYCLES  = TOTAL_BEATS * N_PORTS * 8 + 100;

    typedef struct packed {
        logic [7:0]           port;
        logic [DATA_BITS-1:0] expected;
        logic [DATA_BITS-1:0] actual;
    } read_beat_t;

    logic                 clk;
    logic                 rst;
    logic                 creq      [N_PORTS];
    cache_req_t           req       [N_PORTS];
    logic [DATA_BITS-1:0] dataout   [N_PORTS];
    logic                 port_wait [N_PORTS];

    logic [DATA_BITS-1:0] model [MEM_WORDS];
    read_beat_t           beat_q [$];
    int                   errors;
    int                   checks;
    int                   tests_run;
    int                   errors_before;
    int                   cycles = 0;

    mem_subsys_top #(
        .N_PORTS   (N_PORTS),
        .MEM_WORDS (MEM_WORDS)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .creq_i    (creq),
        .req_i     (req),
        .dataout_o (dataout),
        .wait_o    (port_wait)
    );

    always #50 clk = ~clk;

    // Strobes cover the low lanes only
    function automatic logic [DATA_BITS-1:0] merge_write(
        input logic [DATA_BITS-1:0] old_word,
        input logic [DATA_BITS-1:0] new_word,
        input access_e              width
    );
        case (width)
            ACC_BYTE: return {old_word[31:8], new_word[7:0]};
            ACC_HALF: return {old_word[31:16], new_word[15:0]};
            default:  return new_word;
        endcase
    endfunction

    function automatic int word_index(input logic [ADDR_BITS-1:0] addr);
        return int'(addr[ADDR_BITS-1:2]) % MEM_WORDS;
    endfunction

    // Expected word of one read beat, incrementing burst
    function automatic logic [DATA_BITS-1:0] expected_read(
        input logic [ADDR_BITS-1:0] base,
        input int                   beat
    );
        return model[word_index(base + ADDR_BITS'(4 * beat))];
    endfunction

    function automatic cache_req_t make_request(
        input logic                 write,
        input logic                 one_beat,
        input access_e              width,
        input logic [ADDR_BITS-1:0] addr,
        input logic [DATA_BITS-1:0] wdata
    );
        cache_req_t r;
        r.write    = write;
        r.one_beat = one_beat;
        r.width    = width;
        r.addr     = addr;
        r.wdata    = wdata;
        return r;
    endfunction

    task automatic compare_value(
        input string                name,
        input logic [DATA_BITS-1:0] expected,
        input logic [DATA_BITS-1:0] actual
    );
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    always @(posedge clk) begin : compare_beats
        read_beat_t rec;
        while (beat_q.size() > 0) begin
            rec = beat_q.pop_front();
            compare_value($sformatf("dataout_o[%0d]", rec.port), rec.expected, rec.actual);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, a request never completed", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // Hold the request until every beat has seen wait low
    task automatic issue_request(input int port, input cache_req_t r);
        int beats;
        int done_beats;
        read_beat_t rec;
        beats      = (r.write || r.one_beat) ? 1 : 4;
        done_beats = 0;
        @(posedge clk);
        creq[port] <= 1'b1;
        req[port]  <= r;
        while (done_beats < beats) begin
            @(negedge clk);
            if (!port_wait[port]) begin
                if (r.write) begin
                    model[word_index(r.addr)] =
                        merge_write(model[word_index(r.addr)], r.wdata, r.width);
                end else begin
                    rec.port     = 8'(port);
                    rec.expected = expected_read(r.addr, done_beats);
                    rec.actual   = dataout[port];
                    beat_q.push_back(rec);
                end
                done_beats++;
            end
        end
        @(posedge clk);
        creq[port] <= 1'b0;
    endtask

    task automatic random_traffic(input int port);
        cache_req_t r;
        int offset;
        for (int n = 0; n < RAND_OPS; n++) begin
            offset     = int'($urandom_range(PORT_WORDS - 4, 0));
            r.write    = 1'($urandom_range(1, 0));
            r.one_beat = 1'($urandom_range(1, 0));
            r.width    = access_e'($urandom_range(2, 0));
            r.addr     = ADDR_BITS'((port * PORT_WORDS + offset) * 4);
            r.wdata    = $urandom;
            issue_request(port, r);
            repeat ($urandom_range(2, 0)) @(posedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        repeat (2) @(posedge clk);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        int assert_errors;
        void'($urandom(32'hdee2991e));
        clk = 1'b0;
        rst = 1'b0;
        for (int p = 0; p < N_PORTS; p++) begin
            creq[p] = 1'b0;
            req[p]  = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = '0;
        end
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        errors_before = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;

        repeat (4) @(negedge clk);
        for (int p = 0; p < N_PORTS; p++) begin
            compare_value($sformatf("wait_o[%0d]", p), '0, 32'(port_wait[p]));
        end
        finish_test("idle after reset");

        issue_request(0, make_request(1'b1, 1'b1, ACC_WORD, 32'h40, 32'hcafe_0123));
        issue_request(0, make_request(1'b0, 1'b1, ACC_WORD, 32'h40, '0));
        finish_test("word write then read");

        issue_request(0, make_request(1'b1, 1'b1, ACC_WORD, 32'h80, 32'ha1b2_c3d4));
        issue_request(0, make_request(1'b1, 1'b1, ACC_BYTE, 32'h80, 32'h5566_7788));
        issue_request(0, make_request(1'b0, 1'b1, ACC_WORD, 32'h80, '0));
        issue_request(0, make_request(1'b1, 1'b1, ACC_WORD, 32'h84, 32'h0bad_f00d));
        issue_request(0, make_request(1'b1, 1'b1, ACC_HALF, 32'h84, 32'h1234_5678));
        issue_request(0, make_request(1'b0, 1'b1, ACC_WORD, 32'h84, '0));
        finish_test("byte and halfword merge");

        // Port 1 so the burst returns with ID 1
        for (int i = 0; i < 4; i++) begin
            issue_request(1, make_request(1'b1, 1'b1, ACC_WORD, 32'(32'h200 + 4 * i), $urandom));
        end
        issue_request(1, make_request(1'b0, 1'b0, ACC_WORD, 32'h200, '0));
        finish_test("four beat burst read");

        fork
            random_traffic(0);
            random_traffic(1);
        join
        finish_test("concurrent random traffic");

        assert_errors = dut_i.u_arbiter.u_assertions.assert_errors;
        $display("tests %0d, checks %0d, errors %0d, assertion errors %0d",
                 tests_run, checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog/axi_pkg.sv */
package axi_pkg;

    // Bus widths
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 32;
    localparam int STRB_BITS = DATA_BITS / 8;
    localparam int ID_BITS   = 4;

    localparam logic [7:0] LEN_ONE   = 8'd0;
    localparam logic [7:0] LEN_FOUR  = 8'd3;
    localparam logic [2:0] SIZE_WORD = 3'b010;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    localparam logic [STRB_BITS-1:0] STRB_BYTE = 4'b0001;
    localparam logic [STRB_BITS-1:0] STRB_HALF = 4'b0011;
    localparam logic [STRB_BITS-1:0] STRB_WORD = 4'b1111;

    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10
    } access_e;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } burst_e;

    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_AR   = 3'd1,
        ST_R    = 3'd2,
        ST_AW   = 3'd3,
        ST_W    = 3'd4,
        ST_B    = 3'd5
    } master_state_e;

    // One cache port request
    typedef struct packed {
        logic                 write;
        logic                 one_beat;
        access_e              width;
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] wdata;
    } cache_req_t;

    // Shared by AR and AW
    typedef struct packed {
        logic [ID_BITS-1:0]   id;
        logic [ADDR_BITS-1:0] addr;
        logic [7:0]           len;
        logic [2:0]           size;
        burst_e               burst;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic [STRB_BITS-1:0] strb;
        logic                 last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_BITS-1:0]   id;
        logic [DATA_BITS-1:0] data;
        logic [1:0]           resp;
        logic                 last;
    } axi_r_t;

    typedef struct packed {
        logic [ID_BITS-1:0] id;
        logic [1:0]         resp;
    } axi_b_t;

endpackage

/* verilog/axi_rr_arbiter.sv */
module axi_rr_arbiter #(
    parameter int N_PORTS = 2
) (
    input  logic                clk,
    input  logic                rst,
    // Master side
    input  logic                m_arvalid_i [N_PORTS],
    input  axi_pkg::axi_ar_t    m_ar_i      [N_PORTS],
    output logic                m_arready_o [N_PORTS],
    input  logic                m_awvalid_i [N_PORTS],
    input  axi_pkg::axi_ar_t    m_aw_i      [N_PORTS],
    output logic                m_awready_o [N_PORTS],
    input  logic                m_wvalid_i  [N_PORTS],
    input  axi_pkg::axi_w_t     m_w_i       [N_PORTS],
    output logic                m_wready_o  [N_PORTS],
    output logic                m_rvalid_o  [N_PORTS],
    output axi_pkg::axi_r_t     m_r_o       [N_PORTS],
    input  logic                m_rready_i  [N_PORTS],
    output logic                m_bvalid_o  [N_PORTS],
    output axi_pkg::axi_b_t     m_b_o       [N_PORTS],
    input  logic                m_bready_i  [N_PORTS],
    // Slave side
    output logic                s_arvalid_o,
    output axi_pkg::axi_ar_t    s_ar_o,
    input  logic                s_arready_i,
    output logic                s_awvalid_o,
    output axi_pkg::axi_ar_t    s_aw_o,
    input  logic                s_awready_i,
    output logic                s_wvalid_o,
    output axi_pkg::axi_w_t     s_w_o,
    input  logic                s_wready_i,
    input  logic                s_rvalid_i,
    input  axi_pkg::axi_r_t     s_r_i,
    output logic                s_rready_o,
    input  logic                s_bvalid_i,
    input  axi_pkg::axi_b_t     s_b_i,
    output logic                s_bready_o
);
    import axi_pkg::*;

    localparam int IDX_BITS = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    logic [N_PORTS-1:0]  port_req;
    logic [IDX_BITS-1:0] rr_ptr, grant_q, pick, grant;
    logic                busy, any_req, grant_vld, done;

    always_comb begin
        for (int i = 0; i < N_PORTS; i++) begin
            port_req[i] = m_arvalid_i[i] | m_awvalid_i[i];
        end
    end

    assign any_req = |port_req;

    // First requester at or after the pointer
    always_comb begin
        pick = rr_ptr;
        for (int k = N_PORTS - 1; k >= 0; k--) begin
            if (port_req[(int'(rr_ptr) + k) % N_PORTS]) begin
                pick = IDX_BITS'((int'(rr_ptr) + k) % N_PORTS);
            end
        end
    end

    assign grant     = busy ? grant_q : pick;
    assign grant_vld = busy | any_req;
    assign done      = (s_rvalid_i & s_rready_o & s_r_i.last) | (s_bvalid_i & s_bready_o);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy    <= 1'b0;
            grant_q <= '0;
            rr_ptr  <= '0;
        end else if (!busy) begin
            if (any_req) begin
                busy    <= 1'b1;
                grant_q <= pick;
            end
        end else if (done) begin
            busy   <= 1'b0;
            rr_ptr <= (int'(grant_q) == N_PORTS - 1) ? '0 : grant_q + 1'b1;
        end
    end

    // Request channels, ID replaced by the port index
    always_comb begin
        s_ar_o      = m_ar_i[grant];
        s_ar_o.id   = ID_BITS'(grant);
        s_aw_o      = m_aw_i[grant];
        s_aw_o.id   = ID_BITS'(grant);
        s_w_o       = m_w_i[grant];
        s_arvalid_o = grant_vld & m_arvalid_i[grant];
        s_awvalid_o = grant_vld & m_awvalid_i[grant];
        s_wvalid_o  = busy & m_wvalid_i[grant];
        for (int i = 0; i < N_PORTS; i++) begin
            m_arready_o[i] = grant_vld && (int'(grant) == i) && s_arready_i;
            m_awready_o[i] = grant_vld && (int'(grant) == i) && s_awready_i;
            m_wready_o[i]  = busy && (int'(grant) == i) && s_wready_i;
        end
    end

    // Responses go back by ID
    always_comb begin
        s_rready_o = 1'b0;
        s_bready_o = 1'b0;
        for (int i = 0; i < N_PORTS; i++) begin
            m_r_o[i]      = s_r_i;
            m_b_o[i]      = s_b_i;
            m_rvalid_o[i] = s_rvalid_i && (s_r_i.id == ID_BITS'(i));
            m_bvalid_o[i] = s_bvalid_i && (s_b_i.id == ID_BITS'(i));
            if (s_r_i.id == ID_BITS'(i)) begin
                s_rready_o = m_rready_i[i];
            end
            if (s_b_i.id == ID_BITS'(i)) begin
                s_bready_o = m_bready_i[i];
            end
        end
    end

endmodule

/* verilog/axi_sram_slave.sv */
module axi_sram_slave #(
    parameter int MEM_WORDS = 256
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             arvalid_i,
    input  axi_pkg::axi_ar_t ar_i,
    output logic             arready_o,
    input  logic             awvalid_i,
    input  axi_pkg::axi_ar_t aw_i,
    output logic             awready_o,
    input  logic             wvalid_i,
    input  axi_pkg::axi_w_t  w_i,
    output logic             wready_o,
    output logic             rvalid_o,
    output axi_pkg::axi_r_t  r_o,
    input  logic             rready_i,
    output logic             bvalid_o,
    output axi_pkg::axi_b_t  b_o,
    input  logic             bready_i
);
    import axi_pkg::*;

    localparam int WA_BITS = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef enum logic [1:0] {
        SL_IDLE = 2'd0,
        SL_RD   = 2'd1,
        SL_WD   = 2'd2,
        SL_WB   = 2'd3
    } slave_state_e;

    slave_state_e state;

    logic [DATA_BITS-1:0] mem [MEM_WORDS];
    logic [WA_BITS-1:0]   addr_q;
    logic [ID_BITS-1:0]   id_q;
    logic [7:0]           len_q, cnt_q;
    logic                 incr_q;
    logic                 last_beat;

    assign arready_o = (state == SL_IDLE);
    assign awready_o = (state == SL_IDLE);
    assign wready_o  = (state == SL_WD);
    assign rvalid_o  = (state == SL_RD);
    assign bvalid_o  = (state == SL_WB);
    assign last_beat = (cnt_q == len_q);

    assign r_o.id   = id_q;
    assign r_o.data = mem[addr_q];
    assign r_o.resp = RESP_OKAY;
    assign r_o.last = last_beat;
    assign b_o.id   = id_q;
    assign b_o.resp = RESP_OKAY;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= SL_IDLE;
            addr_q <= '0;
            id_q   <= '0;
            len_q  <= '0;
            cnt_q  <= '0;
            incr_q <= 1'b0;
        end else begin
            case (state)
                SL_IDLE: begin
                    cnt_q <= '0;
                    if (arvalid_i) begin
                        state  <= SL_RD;
                        addr_q <= ar_i.addr[WA_BITS+1:2];
                        id_q   <= ar_i.id;
                        len_q  <= ar_i.len;
                        incr_q <= (ar_i.burst == BURST_INCR);
                    end else if (awvalid_i) begin
                        state  <= SL_WD;
                        addr_q <= aw_i.addr[WA_BITS+1:2];
                        id_q   <= aw_i.id;
                        len_q  <= aw_i.len;
                        incr_q <= (aw_i.burst == BURST_INCR);
                    end
                end
                SL_RD: begin
                    if (rready_i) begin
                        cnt_q  <= cnt_q + 8'd1;
                        addr_q <= incr_q ? addr_q + 1'b1 : addr_q;
                        if (last_beat) state <= SL_IDLE;
                    end
                end
                SL_WD: if (wvalid_i) state <= SL_WB;
                SL_WB: if (bready_i) state <= SL_IDLE;
                default: state <= SL_IDLE;
            endcase
        end
    end

    // Byte lanes merged under the strobe
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wvalid_i && wready_o) begin
            for (int b = 0; b < STRB_BITS; b++) begin
                if (w_i.strb[b]) begin
                    mem[addr_q][8*b +: 8] <= w_i.data[8*b +: 8];
                end
            end
        end
    end

endmodule

/* verilog/cache_axi_master.sv */
module cache_axi_master (
    input  logic                             clk,
    input  logic                             rst,
    // Cache side
    input  logic                             creq_i,
    input  axi_pkg::cache_req_t              req_i,
    output logic [axi_pkg::DATA_BITS-1:0]    dataout_o,
    output logic                             wait_o,
    // Read address
    output logic                             arvalid_o,
    output axi_pkg::axi_ar_t                 ar_o,
    input  logic                             arready_i,
    // Write address
    output logic                             awvalid_o,
    output axi_pkg::axi_ar_t                 aw_o,
    input  logic                             awready_i,
    // Write data
    output logic                             wvalid_o,
    output axi_pkg::axi_w_t                  w_o,
    input  logic                             wready_i,
    // Read data
    input  logic                             rvalid_i,
    input  axi_pkg::axi_r_t                  r_i,
    output logic                             rready_o,
    // Write response
    input  logic                             bvalid_i,
    input  axi_pkg::axi_b_t                  b_i,
    output logic                             bready_o
);
    import axi_pkg::*;

    master_state_e state, nxt;

    logic                 arhns, awhns, whns, rhns, bhns;
    logic [STRB_BITS-1:0] wstrb;
    logic [DATA_BITS-1:0] rdata_q;

    assign arhns    = arvalid_o & arready_i;
    assign awhns    = awvalid_o & awready_i;
    assign whns     = wvalid_o & wready_i;
    assign rhns     = rvalid_i & rready_o;
    assign bhns     = bvalid_i & bready_o;

    always_comb begin
        case (req_i.width)
            ACC_BYTE: wstrb = STRB_BYTE;
            ACC_HALF: wstrb = STRB_HALF;
            default:  wstrb = STRB_WORD;
        endcase
    end

    // Reads are one or four beats, writes always a single beat
    always_comb begin
        ar_o.id    = '0;
        ar_o.addr  = req_i.addr;
        ar_o.len   = req_i.one_beat ? LEN_ONE : LEN_FOUR;
        ar_o.size  = SIZE_WORD;
        ar_o.burst = BURST_INCR;
        aw_o.id    = '0;
        aw_o.addr  = req_i.addr;
        aw_o.len   = LEN_ONE;
        aw_o.size  = SIZE_WORD;
        aw_o.burst = BURST_FIXED;
        w_o.data   = req_i.wdata;
        w_o.strb   = wstrb;
        w_o.last   = 1'b1;
    end

    // Hold the last beat, pass the live one through
    always_ff @(posedge clk) begin
        if (rhns) begin
            rdata_q <= r_i.data;
        end
    end

    assign dataout_o = rhns ? r_i.data : rdata_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            state <= nxt;
        end
    end

    always_comb begin
        nxt = state;
        case (state)
            ST_IDLE: begin
                if (creq_i && req_i.write) begin
                    nxt = awhns ? ST_W : ST_AW;
                end else if (creq_i) begin
                    nxt = arhns ? ST_R : ST_AR;
                end
            end
            ST_AR: if (arhns) nxt = ST_R;
            ST_R:  if (rhns && r_i.last) nxt = ST_IDLE;
            ST_AW: if (awhns) nxt = ST_W;
            ST_W:  if (whns) nxt = ST_B;
            ST_B:  if (bhns) nxt = ST_IDLE;
            default: nxt = ST_IDLE;
        endcase
    end

    always_comb begin
        arvalid_o = 1'b0;
        awvalid_o = 1'b0;
        wvalid_o  = 1'b0;
        rready_o  = 1'b0;
        bready_o  = 1'b0;
        wait_o    = 1'b0;
        case (state)
            ST_IDLE: begin
                arvalid_o = creq_i & ~req_i.write;
                awvalid_o = creq_i & req_i.write;
                wait_o    = creq_i;
            end
            ST_AR: begin
                arvalid_o = 1'b1;
                wait_o    = 1'b1;
            end
            ST_R: begin
                rready_o = 1'b1;
                wait_o   = ~rvalid_i;
            end
            ST_AW: begin
                awvalid_o = 1'b1;
                wait_o    = 1'b1;
            end
            ST_W: begin
                wvalid_o = 1'b1;
                wait_o   = ~wready_i;
            end
            ST_B: begin
                // Write already done for the cache, a new request waits
                bready_o = 1'b1;
                wait_o   = creq_i;
            end
            default: wait_o = 1'b0;
        endcase
    end

endmodule

/* verilog/mem_subsys_top.sv */
module mem_subsys_top #(
    parameter int N_PORTS   = 2,
    parameter int MEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          creq_i    [N_PORTS],
    input  axi_pkg::cache_req_t           req_i     [N_PORTS],
    output logic [axi_pkg::DATA_BITS-1:0] dataout_o [N_PORTS],
    output logic                          wait_o    [N_PORTS]
);
    import axi_pkg::*;

    logic    m_arvalid [N_PORTS], m_arready [N_PORTS];
    logic    m_awvalid [N_PORTS], m_awready [N_PORTS];
    logic    m_wvalid  [N_PORTS], m_wready  [N_PORTS];
    logic    m_rvalid  [N_PORTS], m_rready  [N_PORTS];
    logic    m_bvalid  [N_PORTS], m_bready  [N_PORTS];
    axi_ar_t m_ar [N_PORTS];
    axi_ar_t m_aw [N_PORTS];
    axi_w_t  m_w  [N_PORTS];
    axi_r_t  m_r  [N_PORTS];
    axi_b_t  m_b  [N_PORTS];

    logic    s_arvalid, s_arready, s_awvalid, s_awready, s_wvalid, s_wready;
    logic    s_rvalid, s_rready, s_bvalid, s_bready;
    axi_ar_t s_ar, s_aw;
    axi_w_t  s_w;
    axi_r_t  s_r;
    axi_b_t  s_b;

    for (genvar p = 0; p < N_PORTS; p++) begin : g_port
        cache_axi_master u_master (
            .clk       (clk),
            .rst       (rst),
            .creq_i    (creq_i[p]),
            .req_i     (req_i[p]),
            .dataout_o (dataout_o[p]),
            .wait_o    (wait_o[p]),
            .arvalid_o (m_arvalid[p]),
            .ar_o      (m_ar[p]),
            .arready_i (m_arready[p]),
            .awvalid_o (m_awvalid[p]),
            .aw_o      (m_aw[p]),
            .awready_i (m_awready[p]),
            .wvalid_o  (m_wvalid[p]),
            .w_o       (m_w[p]),
            .wready_i  (m_wready[p]),
            .rvalid_i  (m_rvalid[p]),
            .r_i       (m_r[p]),
            .rready_o  (m_rready[p]),
            .bvalid_i  (m_bvalid[p]),
            .b_i       (m_b[p]),
            .bready_o  (m_bready[p])
        );
    end

    axi_rr_arbiter #(
        .N_PORTS (N_PORTS)
    ) u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .m_arvalid_i (m_arvalid),
        .m_ar_i      (m_ar),
        .m_arready_o (m_arready),
        .m_awvalid_i (m_awvalid),
        .m_aw_i      (m_aw),
        .m_awready_o (m_awready),
        .m_wvalid_i  (m_wvalid),
        .m_w_i       (m_w),
        .m_wready_o  (m_wready),
        .m_rvalid_o  (m_rvalid),
        .m_r_o       (m_r),
        .m_rready_i  (m_rready),
        .m_bvalid_o  (m_bvalid),
        .m_b_o       (m_b),
        .m_bready_i  (m_bready),
        .s_arvalid_o (s_arvalid),
        .s_ar_o      (s_ar),
        .s_arready_i (s_arready),
        .s_awvalid_o (s_awvalid),
        .s_aw_o      (s_aw),
        .s_awready_i (s_awready),
        .s_wvalid_o  (s_wvalid),
        .s_w_o       (s_w),
        .s_wready_i  (s_wready),
        .s_rvalid_i  (s_rvalid),
        .s_r_i       (s_r),
        .s_rready_o  (s_rready),
        .s_bvalid_i  (s_bvalid),
        .s_b_i       (s_b),
        .s_bready_o  (s_bready)
    );

    axi_sram_slave #(
        .MEM_WORDS (MEM_WORDS)
    ) u_slave (
        .clk       (clk),
        .rst       (rst),
        .arvalid_i (s_arvalid),
        .ar_i      (s_ar),
        .arready_o (s_arready),
        .awvalid_i (s_awvalid),
        .aw_i      (s_aw),
        .awready_o (s_awready),
        .wvalid_i  (s_wvalid),
        .w_i       (s_w),
        .wready_o  (s_wready),
        .rvalid_o  (s_rvalid),
        .r_o       (s_r),
        .rready_i  (s_rready),
        .bvalid_o  (s_bvalid),
        .b_o       (s_b),
        .bready_i  (s_bready)
    );

endmodule
